/* hostlink_top.f */
hw/hostlink_pkg.sv
hw/msg_fifo.sv
hw/pc_msg_decode.sv
hw/loopback_exec.sv
hw/fpga_msg_result.sv
hw/hostlink_top.sv
tb/hostlink_tb.sv

/* hw/fpga_msg_result.sv */
`timescale 1ns/1ps

module fpga_msg_result import hostlink_pkg::*; #(
  parameter int MSG_DEPTH = 4
) (
  input  logic      bus_clk,
  input  logic      rst,
  input  fpga_msg_t fpga_msg,
  input  logic      rd_open,
  output logic      fpga_msg_full,
  input  logic      rd_rden,
  output word_t     rd_word,
  output logic      rd_empty
);

  localparam int IDX_W = (WORDS_PER_MSG > 1) ? $clog2(WORDS_PER_MSG) : 1;

  logic                        msg_wr;
  logic                        msg_pop;
  logic [MSG_W-1:0]            msg_head;
  logic                        msg_full;
  logic                        msg_empty;
  word_t [WORDS_PER_MSG-1:0]   head_words;
  logic [IDX_W-1:0]            word_idx;
  logic                        word_adv;
  logic                        last_word;

  // ******************************
  // Message queue
  // ******************************

  // Offers made while the read channel is closed are dropped
  assign msg_wr = fpga_msg.valid && rd_open && !msg_full;

  msg_fifo #(
    .WIDTH (MSG_W),
    .DEPTH (MSG_DEPTH)
  ) u_msg_fifo (
    .bus_clk     (bus_clk),
    .rst         (rst),
    .wr_en       (msg_wr),
    .din         (fpga_msg.data),
    .rd_en       (msg_pop),
    .dout        (msg_head),
    .full        (msg_full),
    .almost_full (),
    .empty       (msg_empty)
  );

  assign fpga_msg_full = msg_full;

  // ******************************
  // Word serializer
  // ******************************

  // Word 0 sits in the low bits of the message
  assign head_words = msg_head;

  assign word_adv  = rd_rden && !msg_empty;
  assign last_word = (word_idx == IDX_W'(WORDS_PER_MSG - 1));

  always_ff @(posedge bus_clk) begin
    if (rst) begin
      word_idx <= '0;
    end else if (word_adv) begin
      if (last_word) begin
        word_idx <= '0;
      end else begin
        word_idx <= word_idx + 1'b1;
      end
    end
  end

  // Free the message on the advance past its last word
  assign msg_pop = word_adv && last_word;

  assign rd_word  = head_words[word_idx];
  assign rd_empty = msg_empty;

endmodule

/* hw/hostlink_pkg.sv */
package hostlink_pkg;

  // ******************************
  // Channel and message widths
  // ******************************

  localparam int WORD_W        = 32;
  localparam int WORDS_PER_MSG = 4;
  localparam int MSG_W         = WORD_W * WORDS_PER_MSG;

  typedef logic [WORD_W-1:0] word_t;

  // A word of all ones closes a host message stream
  localparam word_t END_MARKER = '1;

  // ******************************
  // Bundled channel signals
  // ******************************

  // Application side message offer
  typedef struct packed {
    logic             valid;
    logic [MSG_W-1:0] data;
  } fpga_msg_t;

  // Host write strobe with its word
  typedef struct packed {
    logic  wren;
    word_t data;
  } host_wr_t;

  // Classification of a popped host word
  typedef enum logic {
    kind_data = 1'b0,
    kind_end  = 1'b1
  } word_kind_e;

  // Registered decoder output
  typedef struct packed {
    logic       valid;
    word_kind_e kind;
    word_t      data;
  } pc_word_t;

endpackage

/* hw/hostlink_top.sv */
`timescale 1ns/1ps

module hostlink_top import hostlink_pkg::*; #(
  parameter int WR_DEPTH   = 16,
  parameter int LOOP_DEPTH = 8,
  parameter int MSG_DEPTH  = 4
) (
  input  logic      bus_clk,
  input  logic      rst,
  input  host_wr_t  host_wr,
  input  logic      wr_open,
  output logic      wr_full,
  input  logic      loop_rden,
  output word_t     loop_word,
  output logic      loop_empty,
  output logic      loop_eof,
  input  logic      rd_rden,
  input  logic      rd_open,
  output word_t     rd_word,
  output logic      rd_empty,
  output logic      rd_eof,
  input  fpga_msg_t fpga_msg,
  output logic      fpga_msg_full
);

  word_t    head;
  logic     head_empty;
  logic     pop;
  logic     loop_afull;
  pc_word_t pc_word;

  // ******************************
  // Host write FIFO
  // ******************************

  msg_fifo #(
    .WIDTH (WORD_W),
    .DEPTH (WR_DEPTH)
  ) u_wr_fifo (
    .bus_clk     (bus_clk),
    .rst         (rst),
    .wr_en       (host_wr.wren),
    .din         (host_wr.data),
    .rd_en       (pop),
    .dout        (head),
    .full        (wr_full),
    .almost_full (),
    .empty       (head_empty)
  );

  // ******************************
  // Decode, loopback, read side
  // ******************************

  pc_msg_decode u_decode (
    .bus_clk    (bus_clk),
    .rst        (rst),
    .head       (head),
    .head_empty (head_empty),
    .loop_afull (loop_afull),
    .pop        (pop),
    .pc_word    (pc_word),
    .rd_eof     (rd_eof)
  );

  loopback_exec #(
    .LOOP_DEPTH (LOOP_DEPTH)
  ) u_loopback (
    .bus_clk    (bus_clk),
    .rst        (rst),
    .pc_word    (pc_word),
    .wr_open    (wr_open),
    .loop_afull (loop_afull),
    .loop_rden  (loop_rden),
    .loop_word  (loop_word),
    .loop_empty (loop_empty),
    .loop_eof   (loop_eof)
  );

  fpga_msg_result #(
    .MSG_DEPTH (MSG_DEPTH)
  ) u_result (
    .bus_clk       (bus_clk),
    .rst           (rst),
    .fpga_msg      (fpga_msg),
    .rd_open       (rd_open),
    .fpga_msg_full (fpga_msg_full),
    .rd_rden       (rd_rden),
    .rd_word       (rd_word),
    .rd_empty      (rd_empty)
  );

endmodule

/* hw/loopback_exec.sv */
`timescale 1ns/1ps

module loopback_exec import hostlink_pkg::*; #(
  parameter int LOOP_DEPTH = 8
) (
  input  logic     bus_clk,
  input  logic     rst,
  input  pc_word_t pc_word,
  input  logic     wr_open,
  output logic     loop_afull,
  input  logic     loop_rden,
  output word_t    loop_word,
  output logic     loop_empty,
  output logic     loop_eof
);

  logic  loop_wr;
  word_t loop_din;
  logic  loop_empty_i;

  // End markers go back to the host like any other decoded word
  assign loop_wr  = pc_word.valid;
  assign loop_din = pc_word.data;

  // ******************************
  // Loopback buffer
  // ******************************

  // Almost-full stalls the decoder with room left for the word in flight
  msg_fifo #(
    .WIDTH (WORD_W),
    .DEPTH (LOOP_DEPTH)
  ) u_loop_fifo (
    .bus_clk     (bus_clk),
    .rst         (rst),
    .wr_en       (loop_wr),
    .din         (loop_din),
    .rd_en       (loop_rden),
    .dout        (loop_word),
    .full        (),
    .almost_full (loop_afull),
    .empty       (loop_empty_i)
  );

  assign loop_empty = loop_empty_i;

  // End of file once the writer has closed and everything has drained
  assign loop_eof = !wr_open && loop_empty_i;

endmodule

/* hw/msg_fifo.sv */
`timescale 1ns/1ps

module msg_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 16
) (
  input  logic             bus_clk,
  input  logic             rst,
  input  logic             wr_en,
  input  logic [WIDTH-1:0] din,
  input  logic             rd_en,
  output logic [WIDTH-1:0] dout,
  output logic             full,
  output logic             almost_full,
  output logic             empty
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [CW-1:0]    count;
  logic             wr_ok;
  logic             rd_ok;

  // Writes to a full buffer and reads of an empty one are dropped
  assign wr_ok = wr_en && !full;
  assign rd_ok = rd_en && !empty;

  // Wrap at DEPTH, which need not be a power of two
  function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] ptr);
    if (ptr == AW'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge bus_clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (rd_ok) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Show-ahead, head entry always on dout
  assign dout        = mem[rd_ptr];
  assign full        = (count == CW'(DEPTH));
  assign almost_full = (count >= CW'(DEPTH - 1));
  assign empty       = (count == '0);

endmodule

/* hw/pc_msg_decode.sv */
`timescale 1ns/1ps

module pc_msg_decode import hostlink_pkg::*; (
  input  logic     bus_clk,
  input  logic     rst,
  input  word_t    head,
  input  logic     head_empty,
  input  logic     loop_afull,
  output logic     pop,
  output pc_word_t pc_word,
  output logic     rd_eof
);

  logic       valid_q;
  logic       eof_q;
  word_kind_e kind_q;
  word_t      data_q;
  word_kind_e head_kind;

  // ******************************
  // Pop and classify
  // ******************************

  // Stall while the loopback side has no room for one more word
  assign pop = !head_empty && !loop_afull;

  assign head_kind = (head == END_MARKER) ? kind_end : kind_data;

  // ******************************
  // Output register
  // ******************************

  always_ff @(posedge bus_clk) begin
    if (rst) begin
      valid_q <= 1'b0;
      eof_q   <= 1'b0;
    end else begin
      valid_q <= pop;
      eof_q   <= pop && (head_kind == kind_end);
    end
  end

  // Word and kind only matter while valid_q is set
  always_ff @(posedge bus_clk) begin
    if (pop) begin
      kind_q <= head_kind;
      data_q <= head;
    end
  end

  assign pc_word = '{valid: valid_q, kind: kind_q, data: data_q};

  // One-cycle pulse, aligned with the marker's pc_word
  assign rd_eof = eof_q;

endmodule

/* tb/hostlink_tb.sv */
`timescale 1ns/1ps

module hostlink_tb import hostlink_pkg::*; ();

  localparam int WR_DEPTH   = 16;
  localparam int LOOP_DEPTH = 8;
  localparam int MSG_DEPTH  = 4;

  typedef enum logic [1:0] {
    act_host,
    act_msg,
    act_drain,
    act_fill
  } act_e;

  // One table row
  // Meaning of exp depends on the action
  typedef struct packed {
    act_e             act;
    logic             rnd;
    logic [MSG_W-1:0] data;
    logic             rd_open;
    logic             wr_open;
    logic [31:0]      exp;
  } entry_t;

  logic      bus_clk;
  logic      rst;
  host_wr_t  host_wr;
  logic      wr_open;
  logic      wr_full;
  logic      loop_rden;
  word_t     loop_word;
  logic      loop_empty;
  logic      loop_eof;
  logic      rd_rden;
  logic      rd_open;
  word_t     rd_word;
  logic      rd_empty;
  logic      rd_eof;
  fpga_msg_t fpga_msg;
  logic      fpga_msg_full;

  entry_t tbl[$];
  word_t  loop_q[$];
  word_t  rd_q[$];
  int     eof_count;
  int     exp_eof_count;
  int     cycles;
  int     limit;

  hostlink_top #(
    .WR_DEPTH   (WR_DEPTH),
    .LOOP_DEPTH (LOOP_DEPTH),
    .MSG_DEPTH  (MSG_DEPTH)
  ) dut (
    .bus_clk       (bus_clk),
    .rst           (rst),
    .host_wr       (host_wr),
    .wr_open       (wr_open),
    .wr_full       (wr_full),
    .loop_rden     (loop_rden),
    .loop_word     (loop_word),
    .loop_empty    (loop_empty),
    .loop_eof      (loop_eof),
    .rd_rden       (rd_rden),
    .rd_open       (rd_open),
    .rd_word       (rd_word),
    .rd_empty      (rd_empty),
    .rd_eof        (rd_eof),
    .fpga_msg      (fpga_msg),
    .fpga_msg_full (fpga_msg_full)
  );

  initial bus_clk = 1'b0;
  always #10 bus_clk = ~bus_clk;

  // Count end-of-file pulses on the falling edge
  always @(negedge bus_clk) begin
    if (!rst && rd_eof) begin
      eof_count++;
    end
  end

  always @(posedge bus_clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles > limit) begin
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("TEST FAILED");
      $fatal(1);
    end
  end

  // ******************************
  // Checks and table
  // ******************************

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  function automatic void add_entry(input act_e act, input logic rnd,
                                    input logic [MSG_W-1:0] data, input logic rd_o,
                                    input logic wr_o, input logic [31:0] exp);
    entry_t e;
    e.act     = act;
    e.rnd     = rnd;
    e.data    = data;
    e.rd_open = rd_o;
    e.wr_open = wr_o;
    e.exp     = exp;
    tbl.push_back(e);
  endfunction

  function automatic void build_table();
    int k;
    // Host word rows with exp set for an end marker
    add_entry(act_host, 1'b0, 128'h1111_0001, 1'b0, 1'b1, 0);
    add_entry(act_host, 1'b0, 128'h1111_0001 - 1, 1'b0, 1'b1, 0);
    add_entry(act_host, 1'b1, '0, 1'b0, 1'b1, 0);
    add_entry(act_host, 1'b1, '0, 1'b0, 1'b1, 0);
    add_entry(act_host, 1'b0, 128'hFFFF_FFFF, 1'b0, 1'b1, 1);
    add_entry(act_host, 1'b0, 128'h2222_0005, 1'b0, 1'b1, 0);
    // Drain rows expect this loop_eof level afterwards
    add_entry(act_drain, 1'b0, '0, 1'b0, 1'b1, 0);
    // Message rows with exp set when the message is queued
    add_entry(act_msg, 1'b0, 128'h4444_0003_3333_0002_2222_0001_1111_0000, 1'b1, 1'b1, 1);
    add_entry(act_msg, 1'b1, '0, 1'b1, 1'b1, 1);
    add_entry(act_msg, 1'b0, 128'hDEAD_0003_DEAD_0002_DEAD_0001_DEAD_0000, 1'b0, 1'b1, 0);
    add_entry(act_msg, 1'b1, '0, 1'b1, 1'b1, 1);
    add_entry(act_fill, 1'b0, '0, 1'b1, 1'b1, 0);
    add_entry(act_drain, 1'b0, '0, 1'b1, 1'b1, 0);
    add_entry(act_host, 1'b1, '0, 1'b1, 1'b1, 0);
    add_entry(act_host, 1'b0, 128'hFFFF_FFFF, 1'b1, 1'b1, 1);
    add_entry(act_host, 1'b1, '0, 1'b1, 1'b1, 0);
    add_entry(act_drain, 1'b0, '0, 1'b1, 1'b0, 1);
    // Filler data with bit 0 cleared so no host word is an end marker
    for (k = 0; k < tbl.size(); k++) begin
      if (tbl[k].rnd && tbl[k].act == act_host) begin
        tbl[k].data = {96'b0, $urandom() & 32'hFFFF_FFFE};
      end else if (tbl[k].rnd) begin
        tbl[k].data = {$urandom(), $urandom(), $urandom(), $urandom()};
      end
    end
  endfunction

  // ******************************
  // Channel drivers
  // ******************************

  task automatic send_host_word(input word_t word, input logic open);
    wr_open = open;
    while (wr_full) @(negedge bus_clk);
    host_wr = '{wren: 1'b1, data: word};
    loop_q.push_back(word);
    @(negedge bus_clk);
    host_wr.wren = 1'b0;
    if (open) begin
      check_val("loop_eof", loop_eof, 1'b0);
    end
  endtask

  task automatic offer_msg(input logic [MSG_W-1:0] msg, input logic open, input logic accept);
    int i;
    rd_open  = open;
    fpga_msg = '{valid: 1'b1, data: msg};
    @(negedge bus_clk);
    fpga_msg.valid = 1'b0;
    if (accept) begin
      // Lowest 32 bits leave first
      for (i = 0; i < WORDS_PER_MSG; i++) begin
        rd_q.push_back(msg[i*WORD_W +: WORD_W]);
      end
    end else begin
      check_val("rd_empty", rd_empty, 1'b1);
    end
    while (rd_q.size() > 0) begin
      while (rd_empty) @(negedge bus_clk);
      check_val("rd_word", rd_word, rd_q.pop_front());
      rd_rden = 1'b1;
      @(negedge bus_clk);
      rd_rden = 1'b0;
    end
    check_val("rd_empty", rd_empty, 1'b1);
  endtask

  // Write until the write FIFO pushes back with the loopback channel unread
  task automatic fill_host(input logic open);
    word_t word;
    int    n;
    n       = 0;
    wr_open = open;
    while (!wr_full) begin
      word    = $urandom() & 32'hFFFF_FFFE;
      host_wr = '{wren: 1'b1, data: word};
      loop_q.push_back(word);
      n++;
      @(negedge bus_clk);
    end
    host_wr.wren = 1'b0;
    check_val("words accepted before wr_full", n >= WR_DEPTH, 1'b1);
  endtask

  task automatic drain_loop(input logic open, input logic exp_eof);
    wr_open = open;
    while (loop_q.size() > 0) begin
      while (loop_empty) @(negedge bus_clk);
      check_val("loop_word", loop_word, loop_q.pop_front());
      loop_rden = 1'b1;
      @(negedge bus_clk);
      loop_rden = 1'b0;
    end
    // Nothing further may arrive in the next few cycles
    repeat (4) @(negedge bus_clk);
    check_val("loop_empty", loop_empty, 1'b1);
    check_val("rd_eof pulses", eof_count, exp_eof_count);
    check_val("loop_eof", loop_eof, exp_eof);
  endtask

  // ******************************
  // Main sequence
  // ******************************

  initial begin
    int     seed;
    int     k;
    entry_t e;
    seed          = 55;
    void'($urandom(seed));
    rst           = 1'b1;
    host_wr       = '0;
    wr_open       = 1'b1;
    loop_rden     = 1'b0;
    rd_rden       = 1'b0;
    rd_open       = 1'b0;
    fpga_msg      = '0;
    eof_count     = 0;
    exp_eof_count = 0;
    cycles        = 0;
    limit         = 0;
    build_table();
    limit = 20 * tbl.size() + 200;

    repeat (3) @(posedge bus_clk);
    @(negedge bus_clk);
    check_val("wr_full", wr_full, 1'b0);
    check_val("fpga_msg_full", fpga_msg_full, 1'b0);
    check_val("rd_eof", rd_eof, 1'b0);
    check_val("pc_word.valid", dut.pc_word.valid, 1'b0);
    check_val("loop_empty", loop_empty, 1'b1);
    check_val("rd_empty", rd_empty, 1'b1);
    rst = 1'b0;
    @(negedge bus_clk);

    for (k = 0; k < tbl.size(); k++) begin
      e = tbl[k];
      case (e.act)
        act_host: begin
          exp_eof_count += e.exp;
          send_host_word(e.data[WORD_W-1:0], e.wr_open);
        end
        act_msg:   offer_msg(e.data, e.rd_open, e.exp[0]);
        act_fill:  fill_host(e.wr_open);
        default:   drain_loop(e.wr_open, e.exp[0]);
      endcase
    end

    check_val("loop words left", loop_q.size(), 0);
    check_val("read words left", rd_q.size(), 0);
    $display("TEST OK");
    $finish;
  end

endmodule
